// ==== src/lin_pkg.sv ====
// lin package: widths, gain scaling, reset values and enums for the gain stage
`default_nettype none

package lin_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // input sample
  localparam int dwi = 14;
  // output sample
  localparam int dwo = 14;
  // gain multiplier
  localparam int dwm = 16;
  // offset, same range as the output
  localparam int dws = dwo;
  // clipped sample counter
  localparam int cnt_w = 16;

  ////////////////////////////////////////
  // gain scaling and reset values
  ////////////////////////////////////////

  // product is shifted right by this after the multiply
  localparam int gain_shift = dwm - 2;
  // gain of 16384 passes samples through unchanged
  localparam int gain_unity = 2 ** gain_shift;

  localparam logic signed [dwm-1:0] gain_rst   = dwm'(gain_unity);
  localparam logic signed [dws-1:0] offset_rst = '0;

  // skid buffer occupancy
  typedef enum logic [1:0] {
    skid_empty = 2'd0,
    skid_one   = 2'd1,
    skid_two   = 2'd2
  } skid_state_t;

  // configuration opcodes, acted on while cfg_stb is high
  typedef enum logic [1:0] {
    op_nop    = 2'd0,
    op_gain   = 2'd1,
    op_offset = 2'd2,
    op_clear  = 2'd3
  } cfg_op_t;

endpackage

`default_nettype wire

// ==== src/sample_in.sv ====
// sample_in: two-entry skid buffer on the input stream with a registered ready
`default_nettype none

module sample_in (
  input  logic                           sti,
  input  logic                           reset,
  // upstream stream
  input  logic signed [lin_pkg::dwi-1:0] in_dat,
  input  logic                           in_vld,
  output logic                           in_rdy,
  // toward the gain pipeline
  output logic signed [lin_pkg::dwi-1:0] buf_dat,
  output logic                           buf_vld,
  input  logic                           buf_rdy
);

  lin_pkg::skid_state_t state;
  lin_pkg::skid_state_t state_nxt;

  // ent0 is the older sample and the one offered downstream
  logic signed [lin_pkg::dwi-1:0] ent0;
  logic signed [lin_pkg::dwi-1:0] ent1;

  logic push;
  logic pop;
  logic ld0_in;
  logic ld0_ent1;
  logic ld1_in;

  assign push = in_vld & in_rdy;
  assign pop  = buf_vld & buf_rdy;

  ////////////////////////////////////////
  // occupancy FSM
  ////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    ld0_in    = 1'b0;
    ld0_ent1  = 1'b0;
    ld1_in    = 1'b0;
    case (state)
      lin_pkg::skid_empty: begin
        if (push) begin
          ld0_in    = 1'b1;
          state_nxt = lin_pkg::skid_one;
        end
      end
      lin_pkg::skid_one: begin
        // pass-through when both sides move
        if (push && pop) begin
          ld0_in = 1'b1;
        end else if (push) begin
          ld1_in    = 1'b1;
          state_nxt = lin_pkg::skid_two;
        end else if (pop) begin
          state_nxt = lin_pkg::skid_empty;
        end
      end
      lin_pkg::skid_two: begin
        // in_rdy is low here, only drain
        if (pop) begin
          ld0_ent1  = 1'b1;
          state_nxt = lin_pkg::skid_one;
        end
      end
      default: state_nxt = lin_pkg::skid_empty;
    endcase
  end

  always_ff @(posedge sti) begin
    if (reset) begin
      state  <= lin_pkg::skid_empty;
      in_rdy <= 1'b0;
    end else begin
      state  <= state_nxt;
      // ready drops only once both entries are taken
      in_rdy <= (state_nxt != lin_pkg::skid_two);
    end
  end

  // sample storage
  always_ff @(posedge sti) begin
    if (ld0_in) begin
      ent0 <= in_dat;
    end else if (ld0_ent1) begin
      ent0 <= ent1;
    end
    if (ld1_in) begin
      ent1 <= in_dat;
    end
  end

  assign buf_dat = ent0;
  assign buf_vld = (state != lin_pkg::skid_empty);

endmodule

`default_nettype wire

// ==== src/gain_offset.sv ====
// gain_offset: multiply by gain, shift, add offset and saturate, three register stages
`default_nettype none

module gain_offset (
  input  logic                           sti,
  input  logic                           reset,
  // from the skid buffer
  input  logic signed [lin_pkg::dwi-1:0] buf_dat,
  input  logic                           buf_vld,
  output logic                           buf_rdy,
  // configuration
  input  logic signed [lin_pkg::dwm-1:0] gain,
  input  logic signed [lin_pkg::dws-1:0] offset,
  // toward the output register
  output logic signed [lin_pkg::dwo-1:0] go_dat,
  output logic                           go_clip,
  output logic                           go_vld,
  input  logic                           go_rdy
);

  // full width product
  logic signed [lin_pkg::dwi+lin_pkg::dwm-1:0] mul_dat;
  logic                                        mul_vld;

  // product after the shift, range up to +-16384
  logic signed [lin_pkg::dwi+1:0] shf_dat;
  logic                           shf_rdy;

  // shifted product plus offset
  logic signed [lin_pkg::dwi+1:0] sum_dat;
  logic                           sum_vld;
  logic                           sum_rdy;

  // sum bits from the output sign bit upward
  logic [lin_pkg::dwi+1:lin_pkg::dwo-1] sum_hi;
  logic                                 sat_clip;
  logic                                 sat_sign;
  logic signed [lin_pkg::dwo-1:0]       sat_dat;

  logic buf_trn;
  logic mul_trn;
  logic sum_trn;

  ////////////////////////////////////////
  // stage 1: multiply
  ////////////////////////////////////////

  assign buf_trn = buf_vld & buf_rdy;
  // accept when the stage is empty or drains this cycle
  assign buf_rdy = shf_rdy | ~mul_vld;

  always_ff @(posedge sti) begin
    if (buf_trn) begin
      mul_dat <= buf_dat * gain;
    end
  end

  always_ff @(posedge sti) begin
    if (reset) begin
      mul_vld <= 1'b0;
    end else if (buf_rdy) begin
      mul_vld <= buf_vld;
    end
  end

  // arithmetic shift by gain_shift, just a slice of the product
  // dropping the low bits gives floor rounding
  assign shf_dat = $signed(mul_dat[lin_pkg::dwi+lin_pkg::dwm-1:lin_pkg::gain_shift]);

  ////////////////////////////////////////
  // stage 2: offset
  ////////////////////////////////////////

  assign mul_trn = mul_vld & shf_rdy;
  assign shf_rdy = sum_rdy | ~sum_vld;

  always_ff @(posedge sti) begin
    if (mul_trn) begin
      // offset sign-extends into the wider sum
      sum_dat <= shf_dat + offset;
    end
  end

  always_ff @(posedge sti) begin
    if (reset) begin
      sum_vld <= 1'b0;
    end else if (shf_rdy) begin
      sum_vld <= mul_vld;
    end
  end

  ////////////////////////////////////////
  // stage 3: saturation
  ////////////////////////////////////////

  assign sum_trn = sum_vld & sum_rdy;
  assign sum_rdy = go_rdy | ~go_vld;

  // in range only if every bit above the output sign matches it
  assign sum_hi   = sum_dat[lin_pkg::dwi+1:lin_pkg::dwo-1];
  assign sat_clip = (|sum_hi) & ~(&sum_hi);
  assign sat_sign = sum_dat[lin_pkg::dwi+1];
  // clamp toward the bound on the side of the true sign
  assign sat_dat  = sat_clip ? {sat_sign, {(lin_pkg::dwo-1){~sat_sign}}}
                             : sum_dat[lin_pkg::dwo-1:0];

  always_ff @(posedge sti) begin
    if (sum_trn) begin
      go_dat  <= sat_dat;
      go_clip <= sat_clip;
    end
  end

  always_ff @(posedge sti) begin
    if (reset) begin
      go_vld <= 1'b0;
    end else if (sum_rdy) begin
      go_vld <= sum_vld;
    end
  end

endmodule

`default_nettype wire

// ==== src/lin_cfg.sv ====
// lin_cfg: decodes strobed opcodes into gain and offset registers and a clear pulse
`default_nettype none

module lin_cfg (
  input  logic                           sti,
  input  logic                           reset,
  // strobed configuration, no handshake
  input  logic                           cfg_stb,
  input  lin_pkg::cfg_op_t               cfg_op,
  input  logic [lin_pkg::dwm-1:0]        cfg_dat,
  // decoded outputs
  output logic signed [lin_pkg::dwm-1:0] gain,
  output logic signed [lin_pkg::dws-1:0] offset,
  output logic                           clip_clr
);

  ////////////////////////////////////////
  // opcode decode
  ////////////////////////////////////////

  always_ff @(posedge sti) begin
    if (reset) begin
      gain     <= lin_pkg::gain_rst;
      offset   <= lin_pkg::offset_rst;
      clip_clr <= 1'b0;
    end else begin
      // pulse lasts one cycle unless strobed again
      clip_clr <= 1'b0;
      if (cfg_stb) begin
        case (cfg_op)
          lin_pkg::op_gain: begin
            gain <= $signed(cfg_dat);
          end
          lin_pkg::op_offset: begin
            // offset takes the low bits only
            offset <= $signed(cfg_dat[lin_pkg::dws-1:0]);
          end
          lin_pkg::op_clear: begin
            clip_clr <= 1'b1;
          end
          default: begin
            // op_nop, registers hold
            gain <= gain;
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/sample_out.sv ====
// sample_out: output register stage that also counts clipped samples
`default_nettype none

module sample_out (
  input  logic                           sti,
  input  logic                           reset,
  // from the pipeline
  input  logic signed [lin_pkg::dwo-1:0] go_dat,
  input  logic                           go_clip,
  input  logic                           go_vld,
  output logic                           go_rdy,
  // downstream stream
  output logic signed [lin_pkg::dwo-1:0] out_dat,
  output logic                           out_vld,
  input  logic                           out_rdy,
  // clipping statistics
  input  logic                           clip_clr,
  output logic [lin_pkg::cnt_w-1:0]      clip_count
);

  logic go_trn;
  logic cnt_max;

  ////////////////////////////////////////
  // output register
  ////////////////////////////////////////

  assign go_rdy = out_rdy | ~out_vld;
  assign go_trn = go_vld & go_rdy;

  always_ff @(posedge sti) begin
    if (go_trn) begin
      out_dat <= go_dat;
    end
  end

  always_ff @(posedge sti) begin
    if (reset) begin
      out_vld <= 1'b0;
    end else if (go_rdy) begin
      out_vld <= go_vld;
    end
  end

  ////////////////////////////////////////
  // clipped sample counter
  ////////////////////////////////////////

  // counter sticks at all ones
  assign cnt_max = &clip_count;

  always_ff @(posedge sti) begin
    if (reset) begin
      clip_count <= '0;
    end else if (clip_clr) begin
      // clear beats a same-cycle increment
      clip_count <= '0;
    end else if (go_trn && go_clip && !cnt_max) begin
      // counted when the clipped sample is loaded
      clip_count <= clip_count + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== src/lin_top.sv ====
// lin_top: streaming gain stage, skid buffer, config decoder, pipeline and output
`default_nettype none

module lin_top (
  input  logic                           sti,
  input  logic                           reset,
  // input stream
  input  logic signed [lin_pkg::dwi-1:0] in_dat,
  input  logic                           in_vld,
  output logic                           in_rdy,
  // output stream
  output logic signed [lin_pkg::dwo-1:0] out_dat,
  output logic                           out_vld,
  input  logic                           out_rdy,
  // configuration strobe
  input  logic                           cfg_stb,
  input  lin_pkg::cfg_op_t               cfg_op,
  input  logic [lin_pkg::dwm-1:0]        cfg_dat,
  // number of clipped samples
  output logic [lin_pkg::cnt_w-1:0]      clip_count
);

  // skid buffer to pipeline
  logic signed [lin_pkg::dwi-1:0] buf_dat;
  logic                           buf_vld;
  logic                           buf_rdy;

  // pipeline to output register
  logic signed [lin_pkg::dwo-1:0] go_dat;
  logic                           go_clip;
  logic                           go_vld;
  logic                           go_rdy;

  // decoded configuration
  logic signed [lin_pkg::dwm-1:0] gain;
  logic signed [lin_pkg::dws-1:0] offset;
  logic                           clip_clr;

  ////////////////////////////////////////
  // input side
  ////////////////////////////////////////

  sample_in u_sample_in (
    .sti     (sti),
    .reset   (reset),
    .in_dat  (in_dat),
    .in_vld  (in_vld),
    .in_rdy  (in_rdy),
    .buf_dat (buf_dat),
    .buf_vld (buf_vld),
    .buf_rdy (buf_rdy)
  );

  ////////////////////////////////////////
  // processing
  ////////////////////////////////////////

  lin_cfg u_lin_cfg (
    .sti      (sti),
    .reset    (reset),
    .cfg_stb  (cfg_stb),
    .cfg_op   (cfg_op),
    .cfg_dat  (cfg_dat),
    .gain     (gain),
    .offset   (offset),
    .clip_clr (clip_clr)
  );

  gain_offset u_gain_offset (
    .sti     (sti),
    .reset   (reset),
    .buf_dat (buf_dat),
    .buf_vld (buf_vld),
    .buf_rdy (buf_rdy),
    .gain    (gain),
    .offset  (offset),
    .go_dat  (go_dat),
    .go_clip (go_clip),
    .go_vld  (go_vld),
    .go_rdy  (go_rdy)
  );

  // output side
  sample_out u_sample_out (
    .sti        (sti),
    .reset      (reset),
    .go_dat     (go_dat),
    .go_clip    (go_clip),
    .go_vld     (go_vld),
    .go_rdy     (go_rdy),
    .out_dat    (out_dat),
    .out_vld    (out_vld),
    .out_rdy    (out_rdy),
    .clip_clr   (clip_clr),
    .clip_count (clip_count)
  );

endmodule

`default_nettype wire

// ==== bench/lin_assertions.sv ====
// lin_assertions: concurrent protocol checks on the gain stage top level
`default_nettype none

module lin_assertions (
  input logic                           sti,
  input logic                           reset,
  input logic signed [lin_pkg::dwi-1:0] in_dat,
  input logic                           in_vld,
  input logic                           in_rdy,
  input logic signed [lin_pkg::dwo-1:0] out_dat,
  input logic                           out_vld,
  input logic                           out_rdy,
  input logic                           cfg_stb,
  input lin_pkg::cfg_op_t               cfg_op,
  input logic [lin_pkg::cnt_w-1:0]      clip_count
);

  // failed assertions so far
  int fail_cnt = 0;

  ////////////////////////////////////////
  // reset
  ////////////////////////////////////////

  // every reset edge leaves both handshakes quiet
  reset_quiet: assert property (@(posedge sti) reset |=> (!out_vld && !in_rdy))
    else begin
      $error("out_vld or in_rdy high after a reset cycle");
      fail_cnt++;
    end

  ////////////////////////////////////////
  // stream stability
  ////////////////////////////////////////

  // upstream holds its sample while stalled
  in_hold: assert property (@(posedge sti) disable iff (reset)
    (in_vld && !in_rdy) |=> (in_vld && $stable(in_dat)))
    else begin
      $error("input stream changed while stalled");
      fail_cnt++;
    end

  // output register holds while stalled
  out_hold: assert property (@(posedge sti) disable iff (reset)
    (out_vld && !out_rdy) |=> (out_vld && $stable(out_dat)))
    else begin
      $error("output stream changed while stalled");
      fail_cnt++;
    end

  ////////////////////////////////////////
  // clip counter
  ////////////////////////////////////////

  // strobe, then clip_clr, then the count drops
  clip_mono: assert property (@(posedge sti) disable iff (reset)
    !$past(cfg_stb && (cfg_op == lin_pkg::op_clear), 2) |-> (clip_count >= $past(clip_count)))
    else begin
      $error("clip_count decreased without a clear");
      fail_cnt++;
    end

endmodule

bind lin_top lin_assertions u_lin_assertions (.*);

`default_nettype wire

// ==== bench/lin_tb.sv ====
// lin_tb: testbench for the streaming gain stage with a queue-based reference model
`default_nettype none

module lin_tb;

  logic                           sti;
  logic                           reset;
  logic signed [lin_pkg::dwi-1:0] in_dat;
  logic                           in_vld;
  logic                           in_rdy;
  logic signed [lin_pkg::dwo-1:0] out_dat;
  logic                           out_vld;
  logic                           out_rdy;
  logic                           cfg_stb;
  lin_pkg::cfg_op_t               cfg_op;
  logic [lin_pkg::dwm-1:0]        cfg_dat;
  logic [lin_pkg::cnt_w-1:0]      clip_count;

  // reference model state
  int ref_gain;
  int ref_offset;
  int clip_model;
  int exp_q[$];

  // bookkeeping
  bit rdy_rand;
  int cyc = 0;
  int in_cyc;
  int out_cyc;
  int errors;
  int err_mark;
  int tests_run;
  int tests_failed;
  int timeout_cyc;

  lin_top uut (
    .sti        (sti),
    .reset      (reset),
    .in_dat     (in_dat),
    .in_vld     (in_vld),
    .in_rdy     (in_rdy),
    .out_dat    (out_dat),
    .out_vld    (out_vld),
    .out_rdy    (out_rdy),
    .cfg_stb    (cfg_stb),
    .cfg_op     (cfg_op),
    .cfg_dat    (cfg_dat),
    .clip_count (clip_count)
  );

  always #50 sti = ~sti;

  always @(posedge sti) begin
    cyc <= cyc + 1;
  end

  // downstream ready, random only during the back-pressure test
  always @(posedge sti) begin
    #10;
    out_rdy = rdy_rand ? 1'($urandom) : 1'b1;
  end

  ////////////////////////////////////////
  // reference model and scoreboard
  ////////////////////////////////////////

  function automatic int apply_rule(input int x, output bit clipped);
    int y;
    int hi;
    int lo;
    hi = (1 <<< (lin_pkg::dwo - 1)) - 1;
    lo = -(1 <<< (lin_pkg::dwo - 1));
    // arithmetic shift of a signed int is a floor
    y = ((x * ref_gain) >>> lin_pkg::gain_shift) + ref_offset;
    clipped = (y > hi) || (y < lo);
    if (y > hi) begin
      y = hi;
    end else if (y < lo) begin
      y = lo;
    end
    return y;
  endfunction

  // negedge, so a transfer seen here lands on the next rising edge
  always @(negedge sti) begin
    int exp_val;
    logic [lin_pkg::dwo-1:0] exp_bits;
    if (!reset && out_vld && out_rdy) begin
      out_cyc = cyc + 1;
      assert (exp_q.size() > 0) else begin
        $display("output sample %h arrived with nothing outstanding", out_dat);
        errors++;
      end
      if (exp_q.size() > 0) begin
        exp_val  = exp_q.pop_front();
        exp_bits = exp_val[lin_pkg::dwo-1:0];
        assert (int'(out_dat) == exp_val) else begin
          $display("mismatch out_dat: got %h, expected %h", out_dat, exp_bits);
          errors++;
        end
      end
    end
  end

  function automatic int rand_sample();
    int u;
    logic [lin_pkg::dwi-1:0] r;
    u = $urandom;
    r = u[lin_pkg::dwi-1:0];
    return int'($signed(r));
  endfunction

  function automatic int error_total();
    return errors + uut.u_lin_assertions.fail_cnt;
  endfunction

  ////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////

  // called and returns just after a rising edge
  task automatic send_sample(input int x);
    int t;
    int y;
    bit clipped;
    in_dat = x[lin_pkg::dwi-1:0];
    in_vld = 1'b1;
    t = 0;
    @(negedge sti);
    while (!in_rdy && t < timeout_cyc) begin
      @(negedge sti);
      t++;
    end
    assert (in_rdy) else begin
      $display("timed out waiting for in_rdy");
      errors++;
    end
    if (in_rdy) begin
      // sample is taken on the coming edge, under the current config
      y = apply_rule(x, clipped);
      exp_q.push_back(y);
      if (clipped) begin
        clip_model++;
      end
      in_cyc = cyc + 1;
    end
    @(posedge sti);
    #10;
    in_vld = 1'b0;
  endtask

  task automatic drain();
    int t;
    t = 0;
    while (exp_q.size() > 0 && t < timeout_cyc) begin
      @(posedge sti);
      #10;
      t++;
    end
    assert (exp_q.size() == 0) else begin
      $display("timed out with %0d samples still outstanding", exp_q.size());
      errors++;
    end
  endtask

  task automatic write_cfg(input lin_pkg::cfg_op_t op, input int d);
    // pipeline empty before the config moves
    drain();
    cfg_stb = 1'b1;
    cfg_op  = op;
    cfg_dat = d[lin_pkg::dwm-1:0];
    @(posedge sti);
    #10;
    cfg_stb = 1'b0;
    cfg_op  = lin_pkg::op_nop;
    case (op)
      lin_pkg::op_gain:   ref_gain = int'($signed(d[lin_pkg::dwm-1:0]));
      lin_pkg::op_offset: ref_offset = int'($signed(d[lin_pkg::dws-1:0]));
      lin_pkg::op_clear:  clip_model = 0;
      default:            ref_gain = ref_gain;
    endcase
  endtask

  task automatic check_clip_count();
    logic [lin_pkg::cnt_w-1:0] exp_cnt;
    exp_cnt = clip_model[lin_pkg::cnt_w-1:0];
    assert (int'(clip_count) == clip_model) else begin
      $display("mismatch clip_count: got %h, expected %h", clip_count, exp_cnt);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    int n;
    n = error_total();
    tests_run++;
    if (n == err_mark) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, n - err_mark);
    end
    err_mark = n;
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    int t;
    int i;
    int total;
    void'($urandom(2385));
    sti = 1'b0;
    reset = 1'b1;
    in_dat = '0;
    in_vld = 1'b0;
    out_rdy = 1'b0;
    cfg_stb = 1'b0;
    cfg_op = lin_pkg::op_nop;
    cfg_dat = '0;
    rdy_rand = 1'b0;
    ref_gain = lin_pkg::gain_unity;
    ref_offset = 0;
    clip_model = 0;
    errors = 0;
    err_mark = 0;
    tests_run = 0;
    tests_failed = 0;
    timeout_cyc = 2000;
    repeat (5) @(posedge sti);
    #10;
    reset = 1'b0;

    // reset defaults, unity path and latency
    t = 0;
    while (!in_rdy && t < timeout_cyc) begin
      assert (!out_vld) else begin
        $display("out_vld high before in_rdy rose");
        errors++;
      end
      @(posedge sti);
      #10;
      t++;
    end
    assert (in_rdy) else begin
      $display("in_rdy never rose after reset");
      errors++;
    end
    send_sample(1234);
    drain();
    assert (out_cyc - in_cyc == 5) else begin
      $display("mismatch latency: got %h, expected %h", out_cyc - in_cyc, 5);
      errors++;
    end
    send_sample(-8192);
    drain();
    finish_test("reset_defaults");

    // gain and offset, no stalls
    write_cfg(lin_pkg::op_gain, 12000);
    write_cfg(lin_pkg::op_offset, -300);
    for (i = 0; i < 200; i++) begin
      send_sample(rand_sample());
    end
    drain();
    finish_test("gain_offset");

    // both bounds, then the count
    write_cfg(lin_pkg::op_gain, 30000);
    write_cfg(lin_pkg::op_offset, 2000);
    send_sample(8191);
    send_sample(-8192);
    send_sample(0);
    for (i = 0; i < 100; i++) begin
      send_sample(rand_sample());
    end
    drain();
    check_clip_count();
    finish_test("saturation");

    // random out_rdy, negative gain
    write_cfg(lin_pkg::op_gain, -20000);
    write_cfg(lin_pkg::op_offset, 500);
    rdy_rand = 1'b1;
    for (i = 0; i < 150; i++) begin
      send_sample(rand_sample());
    end
    drain();
    rdy_rand = 1'b0;
    check_clip_count();
    finish_test("back_pressure");

    // nop leaves config alone, clear zeroes the count
    write_cfg(lin_pkg::op_nop, 16'hffff);
    write_cfg(lin_pkg::op_clear, 0);
    @(posedge sti);
    #10;
    check_clip_count();
    // 8191 at gain -20000 lands below the low bound
    send_sample(8191);
    send_sample(100);
    drain();
    check_clip_count();
    finish_test("clear");

    total = error_total();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total);
    if (total == 0 && tests_failed == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
src/lin_pkg.sv
src/sample_in.sv
src/gain_offset.sv
src/lin_cfg.sv
src/sample_out.sv
src/lin_top.sv
bench/lin_assertions.sv
bench/lin_tb.sv

// ==== Makefile ====
SIM       = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = lin_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
RUN_FLAGS = +verilator+error+limit+1000
PASS_MSG  = PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
